// ==== compile.f ====
source/bus_pkg.sv
source/periph_pkg.sv
source/access_sizer.sv
source/byte_req_fifo.sv
source/byte_bus_decoder.sv
source/irq_controller.sv
source/gpio_regs.sv
source/sysbus_top.sv
tests/sysbus_assertions.sv
tests/tb_sysbus.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the log
rm -f sim.log
verilator --binary --assert --top-module tb_sysbus -f compile.f \
    && ./obj_dir/Vtb_sysbus +verilator+error+limit+100 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Test passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== source/access_sizer.sv ====
`timescale 1ns/1ps
`default_nettype none

module access_sizer (
    input  logic                wb_clk_i,
    input  logic                rst_n_i,

    // Word request side
    input  logic                req_valid_i,
    input  bus_pkg::word_req_t  req_i,
    output logic                req_ready_o,
    output logic                rsp_valid_o,
    output bus_pkg::word_rsp_t  rsp_o,

    // Byte accesses towards the FIFO
    output logic                push_valid_o,
    output bus_pkg::byte_req_t  push_req_o,
    input  logic                push_ready_i,

    // Byte replies from the decoder
    input  logic                byte_rsp_valid_i,
    input  bus_pkg::byte_rsp_t  byte_rsp_i
);

    typedef enum logic [1:0] {IDLE, ISSUE, WAIT, DONE} state_t;

    state_t             state;
    bus_pkg::word_req_t req_q;
    bus_pkg::sel_t      issue_lanes;
    bus_pkg::sel_t      rsp_lanes;
    logic [2:0]         pending;
    bus_pkg::word_t     rsp_dat;
    logic               rsp_err;
    logic [1:0]         issue_lane;
    logic [1:0]         rsp_lane;
    logic               push_fire;

    // Lowest selected lane, lanes go out in ascending order
    function automatic logic [1:0] lowest_lane(input bus_pkg::sel_t lanes);
        logic [1:0] lane;
        lane = 2'd0;
        for (int i = 3; i >= 0; i--) begin
            if (lanes[i]) begin
                lane = 2'(i);
            end
        end
        return lane;
    endfunction

    assign issue_lane = lowest_lane(issue_lanes);
    assign rsp_lane   = lowest_lane(rsp_lanes);

    assign req_ready_o  = (state == IDLE);
    assign rsp_valid_o  = (state == DONE);
    assign push_valid_o = (state == ISSUE);
    assign push_fire    = push_valid_o & push_ready_i;

    assign push_req_o.adr = {req_q.adr, issue_lane};
    assign push_req_o.we  = req_q.we;
    assign push_req_o.dat = req_q.dat[issue_lane*8 +: 8];

    assign rsp_o.dat = rsp_dat;
    assign rsp_o.err = rsp_err;

    // --------------------
    // Control
    // --------------------
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            state       <= IDLE;
            issue_lanes <= '0;
            rsp_lanes   <= '0;
            pending     <= '0;
            rsp_err     <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (req_valid_i) begin
                        issue_lanes <= req_i.sel;
                        rsp_lanes   <= req_i.sel;
                        rsp_err     <= 1'b0;
                        // Empty select answers straight away
                        state <= (req_i.sel == '0) ? DONE : ISSUE;
                    end
                end
                ISSUE: begin
                    if (push_fire) begin
                        issue_lanes[issue_lane] <= 1'b0;
                        if (issue_lanes == (bus_pkg::sel_t'(1) << issue_lane)) begin
                            state <= WAIT;
                        end
                    end
                end
                WAIT: begin
                    if (byte_rsp_valid_i && pending == 3'd1) begin
                        state <= DONE;
                    end
                end
                default: state <= IDLE;
            endcase

            // Outstanding replies
            case ({push_fire, byte_rsp_valid_i})
                2'b10:   pending <= pending + 3'd1;
                2'b01:   pending <= pending - 3'd1;
                default: pending <= pending;
            endcase

            if (byte_rsp_valid_i) begin
                rsp_lanes[rsp_lane] <= 1'b0;
                rsp_err             <= rsp_err | byte_rsp_i.err;
            end
        end
    end

    // --------------------
    // Request and response data
    // --------------------
    always_ff @(posedge wb_clk_i) begin
        if (req_valid_i && req_ready_o) begin
            req_q   <= req_i;
            rsp_dat <= '0;
        end
        // Replies come back in issue order
        if (byte_rsp_valid_i) begin
            rsp_dat[rsp_lane*8 +: 8] <= byte_rsp_i.dat;
        end
    end

endmodule

`default_nettype wire

// ==== source/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

    // --------------------
    // Widths
    // --------------------
    localparam int BYTE_ADR_W = 8;

    typedef logic [BYTE_ADR_W-3:0] word_adr_t;
    typedef logic [BYTE_ADR_W-1:0] byte_adr_t;
    typedef logic [7:0]            byte_t;
    typedef logic [31:0]           word_t;
    typedef logic [3:0]            sel_t;

    // --------------------
    // Word bus
    // --------------------
    typedef struct packed {
        word_adr_t adr;
        sel_t      sel;
        logic      we;
        word_t     dat;
    } word_req_t;

    typedef struct packed {
        word_t dat;
        logic  err;
    } word_rsp_t;

    // --------------------
    // Byte bus
    // --------------------
    // Byte address is the word address with the lane number appended
    typedef struct packed {
        byte_adr_t adr;
        logic      we;
        byte_t     dat;
    } byte_req_t;

    typedef struct packed {
        byte_t dat;
        logic  err;
    } byte_rsp_t;

endpackage

`default_nettype wire

// ==== source/byte_bus_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_bus_decoder (
    input  logic                wb_clk_i,
    input  logic                rst_n_i,

    input  logic                pop_valid_i,
    input  bus_pkg::byte_req_t  pop_req_i,
    output logic                pop_ready_o,

    output logic                byte_rsp_valid_o,
    output bus_pkg::byte_rsp_t  byte_rsp_o,

    // Slave side
    output logic                irq_stb_o,
    output logic                gpio_stb_o,
    output periph_pkg::reg_ofs_t ofs_o,
    output logic                we_o,
    output bus_pkg::byte_t      wdat_o,
    input  bus_pkg::byte_t      irq_rdat_i,
    input  bus_pkg::byte_t      gpio_rdat_i
);

    periph_pkg::region_t region;
    bus_pkg::byte_t      sel_byte;
    logic                hit;
    logic                pop_fire;

    // Each access finishes in its pop cycle, so the decoder is never busy
    assign pop_ready_o = 1'b1;
    assign pop_fire    = pop_valid_i & pop_ready_o;

    // Region in the upper nibble, register offset below it
    assign region = pop_req_i.adr[bus_pkg::BYTE_ADR_W-1 -: 4];
    assign ofs_o  = pop_req_i.adr[3:0];
    assign we_o   = pop_req_i.we;
    assign wdat_o = pop_req_i.dat;

    assign irq_stb_o  = pop_fire && (region == periph_pkg::REGION_IRQ);
    assign gpio_stb_o = pop_fire && (region == periph_pkg::REGION_GPIO);

    always_comb begin
        hit      = 1'b1;
        sel_byte = '0;
        case (region)
            periph_pkg::REGION_IRQ:  sel_byte = irq_rdat_i;
            periph_pkg::REGION_GPIO: sel_byte = gpio_rdat_i;
            default:                 hit      = 1'b0;
        endcase
    end

    // --------------------
    // Registered reply
    // --------------------
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            byte_rsp_valid_o <= 1'b0;
        end else begin
            byte_rsp_valid_o <= pop_fire;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (pop_fire) begin
            // Writes and unmapped accesses return zero
            byte_rsp_o.dat <= (pop_req_i.we || !hit) ? '0 : sel_byte;
            byte_rsp_o.err <= ~hit;
        end
    end

endmodule

`default_nettype wire

// ==== source/byte_req_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_req_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic               wb_clk_i,
    input  logic               rst_n_i,

    input  logic               push_valid_i,
    input  bus_pkg::byte_req_t push_req_i,
    output logic               push_ready_o,

    output logic               pop_valid_o,
    output bus_pkg::byte_req_t pop_req_o,
    input  logic               pop_ready_i
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    bus_pkg::byte_req_t mem [FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W:0]     count;
    logic               push_fire;
    logic               pop_fire;

    assign push_ready_o = (count != (PTR_W+1)'(FIFO_DEPTH));
    assign pop_valid_o  = (count != '0);
    assign pop_req_o    = mem[rd_ptr];

    assign push_fire = push_valid_i & push_ready_o;
    assign pop_fire  = pop_valid_o & pop_ready_i;

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_fire, pop_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (push_fire) begin
            mem[wr_ptr] <= push_req_i;
        end
    end

endmodule

`default_nettype wire

// ==== source/gpio_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpio_regs (
    input  logic                 wb_clk_i,
    input  logic                 rst_n_i,

    input  logic                 stb_i,
    input  periph_pkg::reg_ofs_t ofs_i,
    input  logic                 we_i,
    input  bus_pkg::byte_t       wdat_i,
    output bus_pkg::byte_t       rdat_o,

    input  periph_pkg::gpio_t    gpio_i,
    output periph_pkg::gpio_t    gpio_o,
    output periph_pkg::gpio_t    gpio_oe_o,
    output bus_pkg::byte_t       ibase_o
);

    periph_pkg::gpio_t gpio_meta;
    periph_pkg::gpio_t gpio_sync;

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            gpio_o    <= '0;
            gpio_oe_o <= '0;
            ibase_o   <= '0;
        end else if (stb_i && we_i) begin
            // IN is read only
            case (ofs_i)
                periph_pkg::GPIO_OUT:   gpio_o    <= wdat_i;
                periph_pkg::GPIO_DIR:   gpio_oe_o <= wdat_i;
                periph_pkg::GPIO_IBASE: ibase_o   <= wdat_i;
                default:                ;
            endcase
        end
    end

    // Two flop synchronizer on the pins
    always_ff @(posedge wb_clk_i) begin
        gpio_meta <= gpio_i;
        gpio_sync <= gpio_meta;
    end

    always_comb begin
        case (ofs_i)
            periph_pkg::GPIO_OUT:   rdat_o = gpio_o;
            periph_pkg::GPIO_DIR:   rdat_o = gpio_oe_o;
            periph_pkg::GPIO_IN:    rdat_o = gpio_sync;
            periph_pkg::GPIO_IBASE: rdat_o = ibase_o;
            default:                rdat_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/irq_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module irq_controller (
    input  logic                 wb_clk_i,
    input  logic                 rst_n_i,

    input  logic                 stb_i,
    input  periph_pkg::reg_ofs_t ofs_i,
    input  logic                 we_i,
    input  bus_pkg::byte_t       wdat_i,
    output bus_pkg::byte_t       rdat_o,

    input  periph_pkg::irq_vec_t irq_i,
    output periph_pkg::irq_out_t irq_o
);

    localparam int HALF = periph_pkg::IRQ_SOURCES / 2;

    periph_pkg::irq_vec_t pending;
    periph_pkg::irq_vec_t mask;
    periph_pkg::irq_vec_t clear;
    logic                 wr;

    assign wr = stb_i & we_i;

    // Write 1 to clear a pending bit
    always_comb begin
        clear = '0;
        if (wr && ofs_i == periph_pkg::IRQ_PEND_LO) clear[HALF-1:0] = wdat_i;
        if (wr && ofs_i == periph_pkg::IRQ_PEND_HI) clear[HALF +: HALF] = wdat_i;
    end

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            pending <= '0;
            mask    <= '0;
        end else begin
            // Live source wins over a clear
            pending <= (pending & ~clear) | irq_i;
            if (wr && ofs_i == periph_pkg::IRQ_MASK_LO) mask[HALF-1:0] <= wdat_i;
            if (wr && ofs_i == periph_pkg::IRQ_MASK_HI) mask[HALF +: HALF] <= wdat_i;
        end
    end

    always_comb begin
        case (ofs_i)
            periph_pkg::IRQ_PEND_LO: rdat_o = pending[HALF-1:0];
            periph_pkg::IRQ_PEND_HI: rdat_o = pending[HALF +: HALF];
            periph_pkg::IRQ_MASK_LO: rdat_o = mask[HALF-1:0];
            periph_pkg::IRQ_MASK_HI: rdat_o = mask[HALF +: HALF];
            default:                 rdat_o = '0;
        endcase
    end

    assign irq_o[0] = |(pending[HALF-1:0] & mask[HALF-1:0]);
    assign irq_o[1] = |(pending[HALF +: HALF] & mask[HALF +: HALF]);

endmodule

`default_nettype wire

// ==== source/periph_pkg.sv ====
`default_nettype none

package periph_pkg;

    // Upper nibble of the byte address picks the region
    typedef logic [3:0] region_t;
    typedef logic [3:0] reg_ofs_t;

    localparam region_t REGION_IRQ  = 4'h0;
    localparam region_t REGION_GPIO = 4'h1;

    // --------------------
    // Interrupt controller
    // --------------------
    localparam int IRQ_SOURCES = 16;

    typedef logic [IRQ_SOURCES-1:0] irq_vec_t;
    typedef logic [1:0]             irq_out_t;

    localparam reg_ofs_t IRQ_PEND_LO = 4'd0;
    localparam reg_ofs_t IRQ_PEND_HI = 4'd1;
    localparam reg_ofs_t IRQ_MASK_LO = 4'd2;
    localparam reg_ofs_t IRQ_MASK_HI = 4'd3;

    // --------------------
    // GPIO controller
    // --------------------
    typedef logic [7:0] gpio_t;

    localparam reg_ofs_t GPIO_OUT   = 4'd0;
    localparam reg_ofs_t GPIO_DIR   = 4'd1;
    localparam reg_ofs_t GPIO_IN    = 4'd2;
    localparam reg_ofs_t GPIO_IBASE = 4'd3;

endpackage

`default_nettype wire

// ==== source/sysbus_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sysbus_top #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                 wb_clk_i,
    input  logic                 rst_n_i,

    input  logic                 req_valid_i,
    input  bus_pkg::word_req_t   req_i,
    output logic                 req_ready_o,
    output logic                 rsp_valid_o,
    output bus_pkg::word_rsp_t   rsp_o,

    input  periph_pkg::irq_vec_t irq_i,
    output periph_pkg::irq_out_t irq_o,

    input  periph_pkg::gpio_t    gpio_i,
    output periph_pkg::gpio_t    gpio_o,
    output periph_pkg::gpio_t    gpio_oe_o,
    output bus_pkg::byte_t       ibase_o
);

    logic                 push_valid;
    logic                 push_ready;
    bus_pkg::byte_req_t   push_req;
    logic                 pop_valid;
    logic                 pop_ready;
    bus_pkg::byte_req_t   pop_req;
    logic                 byte_rsp_valid;
    bus_pkg::byte_rsp_t   byte_rsp;

    // Shared byte bus towards the slaves
    logic                 irq_stb;
    logic                 gpio_stb;
    periph_pkg::reg_ofs_t ofs;
    logic                 we;
    bus_pkg::byte_t       wdat;
    bus_pkg::byte_t       irq_rdat;
    bus_pkg::byte_t       gpio_rdat;

    // --------------------
    // Word to byte path
    // --------------------
    access_sizer u_sizer (
        .wb_clk_i         ( wb_clk_i       ),
        .rst_n_i          ( rst_n_i        ),
        .req_valid_i      ( req_valid_i    ),
        .req_i            ( req_i          ),
        .req_ready_o      ( req_ready_o    ),
        .rsp_valid_o      ( rsp_valid_o    ),
        .rsp_o            ( rsp_o          ),
        .push_valid_o     ( push_valid     ),
        .push_req_o       ( push_req       ),
        .push_ready_i     ( push_ready     ),
        .byte_rsp_valid_i ( byte_rsp_valid ),
        .byte_rsp_i       ( byte_rsp       )
    );

    byte_req_fifo #(
        .FIFO_DEPTH ( FIFO_DEPTH )
    ) u_fifo (
        .wb_clk_i     ( wb_clk_i   ),
        .rst_n_i      ( rst_n_i    ),
        .push_valid_i ( push_valid ),
        .push_req_i   ( push_req   ),
        .push_ready_o ( push_ready ),
        .pop_valid_o  ( pop_valid  ),
        .pop_req_o    ( pop_req    ),
        .pop_ready_i  ( pop_ready  )
    );

    byte_bus_decoder u_decoder (
        .wb_clk_i         ( wb_clk_i       ),
        .rst_n_i          ( rst_n_i        ),
        .pop_valid_i      ( pop_valid      ),
        .pop_req_i        ( pop_req        ),
        .pop_ready_o      ( pop_ready      ),
        .byte_rsp_valid_o ( byte_rsp_valid ),
        .byte_rsp_o       ( byte_rsp       ),
        .irq_stb_o        ( irq_stb        ),
        .gpio_stb_o       ( gpio_stb       ),
        .ofs_o            ( ofs            ),
        .we_o             ( we             ),
        .wdat_o           ( wdat           ),
        .irq_rdat_i       ( irq_rdat       ),
        .gpio_rdat_i      ( gpio_rdat      )
    );

    // --------------------
    // Byte slaves
    // --------------------
    irq_controller u_irq (
        .wb_clk_i ( wb_clk_i ),
        .rst_n_i  ( rst_n_i  ),
        .stb_i    ( irq_stb  ),
        .ofs_i    ( ofs      ),
        .we_i     ( we       ),
        .wdat_i   ( wdat     ),
        .rdat_o   ( irq_rdat ),
        .irq_i    ( irq_i    ),
        .irq_o    ( irq_o    )
    );

    gpio_regs u_gpio (
        .wb_clk_i  ( wb_clk_i  ),
        .rst_n_i   ( rst_n_i   ),
        .stb_i     ( gpio_stb  ),
        .ofs_i     ( ofs       ),
        .we_i      ( we        ),
        .wdat_i    ( wdat      ),
        .rdat_o    ( gpio_rdat ),
        .gpio_i    ( gpio_i    ),
        .gpio_o    ( gpio_o    ),
        .gpio_oe_o ( gpio_oe_o ),
        .ibase_o   ( ibase_o   )
    );

endmodule

`default_nettype wire

// ==== tests/sysbus_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module sysbus_assertions (
    input logic               wb_clk_i,
    input logic               rst_n_i,
    input logic               req_valid_i,
    input logic               req_ready_i,
    input logic               rsp_valid_i,
    input logic               push_valid_i,
    input logic               push_ready_i,
    input bus_pkg::byte_req_t push_req_i
);

    int push_fails   = 0;
    int accept_fails = 0;
    int busy_fails   = 0;
    int pulse_fails  = 0;
    int fail_count;
    logic busy;

    assign fail_count = push_fails + accept_fails + busy_fails + pulse_fails;

    // --------------------
    // Byte push toward the FIFO
    // --------------------
    push_held: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        push_valid_i && !push_ready_i |=> push_valid_i && $stable(push_req_i))
        else begin
            push_fails++;
            $error("byte push changed while the FIFO was full");
        end

    // --------------------
    // Word request side
    // --------------------
    // Word access in flight from acceptance until its response
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            busy <= 1'b0;
        end else if (req_valid_i && req_ready_i) begin
            busy <= 1'b1;
        end else if (rsp_valid_i) begin
            busy <= 1'b0;
        end
    end

    accept_blocks: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        req_valid_i && req_ready_i |=> !req_ready_i)
        else begin
            accept_fails++;
            $error("req_ready_o stayed high after an accepted request");
        end

    busy_blocks: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        busy |-> !req_ready_i)
        else begin
            busy_fails++;
            $error("req_ready_o high while an access is outstanding");
        end

    rsp_pulse: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        rsp_valid_i |=> !rsp_valid_i)
        else begin
            pulse_fails++;
            $error("rsp_valid_o lasted more than one cycle");
        end

endmodule

bind access_sizer sysbus_assertions u_sizer_assertions (
    .wb_clk_i      ( wb_clk_i     ),
    .rst_n_i       ( rst_n_i      ),
    .req_valid_i   ( req_valid_i  ),
    .req_ready_i   ( req_ready_o  ),
    .rsp_valid_i   ( rsp_valid_o  ),
    .push_valid_i  ( push_valid_o ),
    .push_ready_i  ( push_ready_i ),
    .push_req_i    ( push_req_o   )
);

`default_nettype wire

// ==== tests/tb_sysbus.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sysbus;

    localparam int unsigned SEED = 32'h8a0b_9671;

    // Word address of a slave is its region nibble with offset bits [3:2] at zero
    localparam bus_pkg::word_adr_t IRQ_WORD  = {periph_pkg::REGION_IRQ, 2'b00};
    localparam bus_pkg::word_adr_t GPIO_WORD = {periph_pkg::REGION_GPIO, 2'b00};
    localparam bus_pkg::word_adr_t HOLE_WORD = 6'h20;

    typedef struct packed {
        periph_pkg::irq_vec_t irq;
        periph_pkg::gpio_t    gin;
        bus_pkg::word_req_t   req;
        bus_pkg::word_t       exp_dat;
        logic                 exp_err;
        periph_pkg::irq_out_t exp_irq;
        periph_pkg::gpio_t    exp_out;
        periph_pkg::gpio_t    exp_dir;
        bus_pkg::byte_t       exp_ibase;
    } entry_t;

    logic                 clk;
    logic                 rst_n;
    logic                 req_valid;
    bus_pkg::word_req_t   req;
    logic                 req_ready;
    logic                 rsp_valid;
    bus_pkg::word_rsp_t   rsp;
    periph_pkg::irq_vec_t irq_in;
    periph_pkg::irq_out_t irq_out;
    periph_pkg::gpio_t    gpio_in;
    periph_pkg::gpio_t    gpio_out;
    periph_pkg::gpio_t    gpio_oe;
    bus_pkg::byte_t       ibase;

    // Register model of the GPIO slave
    periph_pkg::gpio_t    out_m;
    periph_pkg::gpio_t    dir_m;
    bus_pkg::byte_t       ibase_m;

    entry_t               table_q[$];
    int                   err_cnt     = 0;
    int                   check_cnt   = 0;
    int                   cycle_cnt   = 0;
    int                   cycle_limit = 50;

    sysbus_top #(
        .FIFO_DEPTH ( 4 )
    ) dut0 (
        .wb_clk_i    ( clk       ),
        .rst_n_i     ( rst_n     ),
        .req_valid_i ( req_valid ),
        .req_i       ( req       ),
        .req_ready_o ( req_ready ),
        .rsp_valid_o ( rsp_valid ),
        .rsp_o       ( rsp       ),
        .irq_i       ( irq_in    ),
        .irq_o       ( irq_out   ),
        .gpio_i      ( gpio_in   ),
        .gpio_o      ( gpio_out  ),
        .gpio_oe_o   ( gpio_oe   ),
        .ibase_o     ( ibase     )
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Test failed");
            $finish;
        end
    end

    // Masked OR per half of the interrupt sources
    function automatic periph_pkg::irq_out_t masked_irq(input periph_pkg::irq_vec_t pend,
                                                        input periph_pkg::irq_vec_t mask);
        return {|(pend[15:8] & mask[15:8]), |(pend[7:0] & mask[7:0])};
    endfunction

    task automatic report_mismatch(input string name, input int idx,
                                   input logic [31:0] got, input logic [31:0] exp);
        err_cnt++;
        $display("MISMATCH %s (entry %0d): got 0x%h, expected 0x%h", name, idx, got, exp);
    endtask

    task automatic add_entry(input periph_pkg::irq_vec_t irq, input periph_pkg::gpio_t gin,
                             input bus_pkg::word_adr_t adr, input bus_pkg::sel_t sel,
                             input logic we, input bus_pkg::word_t dat,
                             input bus_pkg::word_t exp_dat, input logic exp_err,
                             input periph_pkg::irq_out_t exp_irq);
        entry_t e;
        e.irq       = irq;
        e.gin       = gin;
        e.req.adr   = adr;
        e.req.sel   = sel;
        e.req.we    = we;
        e.req.dat   = dat;
        e.exp_dat   = exp_dat;
        e.exp_err   = exp_err;
        e.exp_irq   = exp_irq;
        e.exp_out   = out_m;
        e.exp_dir   = dir_m;
        e.exp_ibase = ibase_m;
        table_q.push_back(e);
    endtask

    task automatic build_table();
        periph_pkg::gpio_t    g1;
        periph_pkg::gpio_t    g2;
        bus_pkg::word_t       wr_dat;
        periph_pkg::irq_vec_t irq_pat;
        periph_pkg::irq_vec_t mask_pat;
        g1       = 8'($urandom);
        g2       = 8'($urandom);
        irq_pat  = 16'h8104;
        mask_pat = 16'h8002;

        // --------------------
        // GPIO registers
        // --------------------
        // Lane 2 hits IN and carries junk
        wr_dat  = $urandom;
        out_m   = wr_dat[7:0];
        dir_m   = wr_dat[15:8];
        ibase_m = wr_dat[31:24];
        add_entry('0, g1, GPIO_WORD, 4'b1111, 1'b1, wr_dat, '0, 1'b0, 2'b00);
        add_entry('0, g1, GPIO_WORD, 4'b1011, 1'b0, '0, {ibase_m, 8'h00, dir_m, out_m},
                  1'b0, 2'b00);
        add_entry('0, g1, GPIO_WORD, 4'b0100, 1'b0, '0, {8'h00, g1, 16'h0000}, 1'b0, 2'b00);
        add_entry('0, g2, GPIO_WORD, 4'b0011, 1'b0, '0, {16'h0000, dir_m, out_m}, 1'b0, 2'b00);
        add_entry('0, g2, GPIO_WORD, 4'b0100, 1'b0, '0, {8'h00, g2, 16'h0000}, 1'b0, 2'b00);

        // --------------------
        // Interrupts
        // --------------------
        // Sources held high during the mask write
        add_entry(irq_pat, g2, IRQ_WORD, 4'b1100, 1'b1, {mask_pat, 16'h0000}, '0, 1'b0,
                  masked_irq(irq_pat, mask_pat));
        add_entry('0, g2, IRQ_WORD, 4'b1111, 1'b0, '0, {mask_pat, irq_pat}, 1'b0,
                  masked_irq(irq_pat, mask_pat));
        add_entry('0, g2, IRQ_WORD, 4'b0011, 1'b1, {16'h0000, irq_pat}, '0, 1'b0, 2'b00);
        add_entry('0, g2, IRQ_WORD, 4'b1111, 1'b0, '0, {mask_pat, 16'h0000}, 1'b0, 2'b00);

        // Unmapped region, then a mapped access
        add_entry('0, g2, HOLE_WORD, 4'b1111, 1'b0, '0, '0, 1'b1, 2'b00);
        add_entry('0, g2, HOLE_WORD, 4'b0101, 1'b1, $urandom, '0, 1'b1, 2'b00);
        add_entry('0, g2, GPIO_WORD, 4'b0001, 1'b0, '0, {24'h000000, out_m}, 1'b0, 2'b00);

        // Empty select touches nothing
        add_entry('0, g2, GPIO_WORD, 4'b0000, 1'b1, $urandom, '0, 1'b0, 2'b00);

        // Back-to-back full words
        for (int k = 0; k < 3; k++) begin
            wr_dat  = $urandom;
            out_m   = wr_dat[7:0];
            dir_m   = wr_dat[15:8];
            ibase_m = wr_dat[31:24];
            add_entry('0, g2, GPIO_WORD, 4'b1111, 1'b1, wr_dat, '0, 1'b0, 2'b00);
            add_entry('0, g2, GPIO_WORD, 4'b1111, 1'b0, '0, {ibase_m, g2, dir_m, out_m},
                      1'b0, 2'b00);
        end
    endtask

    task automatic check_reset_values();
        if (req_ready !== 1'b1) report_mismatch("req_ready_o", -1, 32'(req_ready), 32'h1);
        if (rsp_valid !== 1'b0) report_mismatch("rsp_valid_o", -1, 32'(rsp_valid), 32'h0);
        if (irq_out !== 2'b00) report_mismatch("irq_o", -1, 32'(irq_out), 32'h0);
        if (gpio_out !== 8'h00) report_mismatch("gpio_o", -1, 32'(gpio_out), 32'h0);
        if (gpio_oe !== 8'h00) report_mismatch("gpio_oe_o", -1, 32'(gpio_oe), 32'h0);
        if (ibase !== 8'h00) report_mismatch("ibase_o", -1, 32'(ibase), 32'h0);
    endtask

    // Starts and ends on a falling edge
    task automatic apply_entry(input int idx);
        entry_t e;
        e         = table_q[idx];
        irq_in    = e.irq;
        gpio_in   = e.gin;
        req       = e.req;
        req_valid = 1'b1;
        while (!req_ready) @(negedge clk);
        @(negedge clk);
        req_valid = 1'b0;
        while (!rsp_valid) @(negedge clk);
        check_cnt++;
        if (rsp.dat !== e.exp_dat) report_mismatch("rsp_o.dat", idx, rsp.dat, e.exp_dat);
        if (rsp.err !== e.exp_err) report_mismatch("rsp_o.err", idx, 32'(rsp.err),
                                                   32'(e.exp_err));
        if (irq_out !== e.exp_irq) report_mismatch("irq_o", idx, 32'(irq_out), 32'(e.exp_irq));
        if (gpio_out !== e.exp_out) report_mismatch("gpio_o", idx, 32'(gpio_out),
                                                    32'(e.exp_out));
        if (gpio_oe !== e.exp_dir) report_mismatch("gpio_oe_o", idx, 32'(gpio_oe),
                                                   32'(e.exp_dir));
        if (ibase !== e.exp_ibase) report_mismatch("ibase_o", idx, 32'(ibase),
                                                   32'(e.exp_ibase));
    endtask

    initial begin
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        irq_in    = '0;
        gpio_in   = '0;
        out_m     = '0;
        dir_m     = '0;
        ibase_m   = '0;
        void'($urandom(SEED));
        build_table();
        cycle_limit = 40 * table_q.size() + 50;

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_reset_values();

        for (int i = 0; i < table_q.size(); i++) begin
            apply_entry(i);
        end

        $display("Responses checked: %0d, value errors: %0d, assertion failures: %0d",
                 check_cnt, err_cnt, dut0.u_sizer.u_sizer_assertions.fail_count);
        err_cnt += dut0.u_sizer.u_sizer_assertions.fail_count;
        if (err_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
